// File: Makefile
# Verilator build and run for the data cache testbench

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_dcache
FILELIST  = dcache.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dcache.f
+incdir+rtl
rtl/cache_bus_pkg.sv
rtl/cache_geom_pkg.sv
rtl/req_queue.sv
rtl/tag_lookup.sv
rtl/way_data_ram.sv
rtl/miss_engine.sv
rtl/dcache_top.sv
testbench/mem_model.sv
testbench/tb_dcache.sv

// File: rtl/cache_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache bus types
// core and memory transfers, tag array update
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "dcache_defs.svh"

package cache_bus_pkg;

    typedef struct packed {
        logic                  write;
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_DATA_W-1:0] wdata;
        logic [`DC_MASK_W-1:0] mask;
    } dc_req_t;

    typedef struct packed {
        logic [`DC_DATA_W-1:0] rdata;
        logic                  write;
    } dc_resp_t;

    typedef struct packed {
        logic                  write;
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_DATA_W-1:0] wdata;
    } dc_mem_req_t;

    // write of one way's tag entry plus the set's lru bit
    typedef struct packed {
        logic                   en;
        logic                   way;
        logic [`DC_INDEX_W-1:0] index;
        logic [`DC_TAG_W-1:0]   tag;
        logic                   valid;
        logic                   dirty;
        logic                   lru_way;
    } dc_tag_upd_t;

endpackage

// File: rtl/cache_geom_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache geometry types
// address split and tag lookup result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "dcache_defs.svh"

package cache_geom_pkg;

    typedef logic [`DC_TAG_W-1:0]   dc_tag_t;
    typedef logic [`DC_INDEX_W-1:0] dc_index_t;

    typedef struct packed {
        dc_tag_t                 tag;
        dc_index_t               index;
        logic [`DC_OFFSET_W-1:0] offset;
    } dc_addr_fields_t;

    // same 64 bits, seen raw or split into fields
    typedef union packed {
        logic [`DC_ADDR_W-1:0] raw;
        dc_addr_fields_t       f;
    } dc_addr_u;

    typedef struct packed {
        cache_bus_pkg::dc_req_t req;
        logic                   hit;
        logic                   hit_way;
        logic                   victim_way;
        logic                   victim_valid;
        logic                   victim_dirty;
        dc_tag_t                victim_tag;
    } dc_lookup_t;

endpackage

// File: rtl/dcache_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dcache sizes
// widths, set and way counts, request credits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

`define DC_ADDR_W   64
`define DC_DATA_W   64
`define DC_MASK_W   8
`define DC_INDEX_W  6
`define DC_OFFSET_W 3
`define DC_TAG_W    55
`define DC_SETS     64
`define DC_WAYS     2

// queue depth, also the credits the core starts with
`define DC_CREDITS  4

`endif

// File: rtl/dcache_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dcache top
// request queue, tag lookup, data array, miss engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid_i,
    input  cache_bus_pkg::dc_req_t      req_i,
    output logic                        credit_o,
    output logic                        resp_valid_o,
    output cache_bus_pkg::dc_resp_t     resp_o,
    output logic                        mem_req_valid_o,
    output cache_bus_pkg::dc_mem_req_t  mem_req_o,
    input  logic                        mem_ack_i,
    input  logic [`DC_DATA_W-1:0]       mem_rdata_i
);

    logic                                 head_valid;
    cache_bus_pkg::dc_req_t               head;
    logic                                 pop;
    logic                                 engine_idle;
    logic                                 res_valid;
    cache_geom_pkg::dc_lookup_t           res;
    cache_bus_pkg::dc_tag_upd_t           upd;
    logic [`DC_WAYS-1:0][`DC_DATA_W-1:0]  ram_data;
    logic                                 wr_en;
    logic                                 wr_way;
    cache_geom_pkg::dc_index_t            wr_index;
    logic [`DC_DATA_W-1:0]                wr_data;
    logic [`DC_MASK_W-1:0]                wr_mask;

    req_queue u_queue (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .head_valid_o (head_valid),
        .head_o       (head),
        .pop_i        (pop),
        .credit_o     (credit_o)
    );

    tag_lookup u_lookup (
        .clk           (clk),
        .rst           (rst),
        .head_valid_i  (head_valid),
        .head_i        (head),
        .engine_idle_i (engine_idle),
        .pop_o         (pop),
        .res_valid_o   (res_valid),
        .res_o         (res),
        .upd_i         (upd)
    );

    // data read runs alongside the tag compare on the head's set
    way_data_ram u_data (
        .clk        (clk),
        .rd_index_i (head.addr[`DC_OFFSET_W +: `DC_INDEX_W]),
        .rd_data_o  (ram_data),
        .wr_en_i    (wr_en),
        .wr_way_i   (wr_way),
        .wr_index_i (wr_index),
        .wr_data_i  (wr_data),
        .wr_mask_i  (wr_mask)
    );

    miss_engine u_engine (
        .clk             (clk),
        .rst             (rst),
        .res_valid_i     (res_valid),
        .res_i           (res),
        .ram_data_i      (ram_data),
        .idle_o          (engine_idle),
        .wr_en_o         (wr_en),
        .wr_way_o        (wr_way),
        .wr_index_o      (wr_index),
        .wr_data_o       (wr_data),
        .wr_mask_o       (wr_mask),
        .upd_o           (upd),
        .resp_valid_o    (resp_valid_o),
        .resp_o          (resp_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_ack_i       (mem_ack_i),
        .mem_rdata_i     (mem_rdata_i)
    );

endmodule

// File: rtl/miss_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// miss engine
// hit update, dirty write-back, refill, store merge
// and core response, one request at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "dcache_defs.svh"

module miss_engine (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                res_valid_i,
    input  cache_geom_pkg::dc_lookup_t          res_i,
    input  logic [`DC_WAYS-1:0][`DC_DATA_W-1:0] ram_data_i,
    output logic                                idle_o,
    output logic                                wr_en_o,
    output logic                                wr_way_o,
    output cache_geom_pkg::dc_index_t           wr_index_o,
    output logic [`DC_DATA_W-1:0]               wr_data_o,
    output logic [`DC_MASK_W-1:0]               wr_mask_o,
    output cache_bus_pkg::dc_tag_upd_t          upd_o,
    output logic                                resp_valid_o,
    output cache_bus_pkg::dc_resp_t             resp_o,
    output logic                                mem_req_valid_o,
    output cache_bus_pkg::dc_mem_req_t          mem_req_o,
    input  logic                                mem_ack_i,
    input  logic [`DC_DATA_W-1:0]               mem_rdata_i
);

    typedef enum logic [2:0] {
        st_idle,
        st_hit,
        st_wb,
        st_refill,
        st_resp
    } state_t;

    state_t                     state_q;
    cache_geom_pkg::dc_lookup_t lk_q;
    logic [`DC_DATA_W-1:0]      data_q;
    logic [`DC_DATA_W-1:0]      merged;
    logic                       way;
    logic                       finish;
    cache_geom_pkg::dc_addr_u   req_addr;
    cache_geom_pkg::dc_addr_u   wb_addr;
    cache_geom_pkg::dc_addr_u   fill_addr;

    assign idle_o = (state_q == st_idle);
    assign finish = (state_q == st_hit) || (state_q == st_resp);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q      <= st_idle;
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= finish;
            case (state_q)
                st_idle: begin
                    if (res_valid_i) begin
                        if (res_i.hit) begin
                            state_q <= st_hit;
                        end else if (res_i.victim_valid && res_i.victim_dirty) begin
                            state_q <= st_wb;
                        end else begin
                            state_q <= st_refill;
                        end
                    end
                end
                st_wb: begin
                    if (mem_ack_i) begin
                        state_q <= st_refill;
                    end
                end
                st_refill: begin
                    if (mem_ack_i) begin
                        state_q <= st_resp;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // data_q holds the hit or victim word, then the refilled word
    always_ff @(posedge clk) begin
        if ((state_q == st_idle) && res_valid_i) begin
            lk_q   <= res_i;
            data_q <= ram_data_i[res_i.hit ? res_i.hit_way : res_i.victim_way];
        end else if ((state_q == st_refill) && mem_ack_i) begin
            data_q <= mem_rdata_i;
        end
        if (finish) begin
            resp_o.rdata <= merged;
            resp_o.write <= lk_q.req.write;
        end
    end

    always_comb begin
        for (int b = 0; b < `DC_MASK_W; b++) begin
            if (lk_q.req.write && lk_q.req.mask[b]) begin
                merged[8*b +: 8] = lk_q.req.wdata[8*b +: 8];
            end else begin
                merged[8*b +: 8] = data_q[8*b +: 8];
            end
        end
    end

    always_comb begin
        req_addr.raw     = lk_q.req.addr;
        wb_addr.f.tag    = lk_q.victim_tag;
        wb_addr.f.index  = req_addr.f.index;
        wb_addr.f.offset = '0;
        fill_addr        = req_addr;
        fill_addr.f.offset = '0;
        way = (state_q == st_hit) ? lk_q.hit_way : lk_q.victim_way;

        // hit store writes its bytes, refill writes the whole merged word
        wr_en_o    = (state_q == st_resp) || ((state_q == st_hit) && lk_q.req.write);
        wr_way_o   = way;
        wr_index_o = req_addr.f.index;
        wr_data_o  = (state_q == st_hit) ? lk_q.req.wdata : merged;
        wr_mask_o  = (state_q == st_hit) ? lk_q.req.mask : '1;

        upd_o.en      = finish;
        upd_o.way     = way;
        upd_o.index   = req_addr.f.index;
        upd_o.tag     = req_addr.f.tag;
        upd_o.valid   = 1'b1;
        upd_o.dirty   = lk_q.req.write;
        upd_o.lru_way = way;

        mem_req_valid_o = (state_q == st_wb) || (state_q == st_refill);
        mem_req_o.write = (state_q == st_wb);
        mem_req_o.addr  = (state_q == st_wb) ? wb_addr.raw : fill_addr.raw;
        mem_req_o.wdata = data_q;
    end

endmodule

// File: rtl/req_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request queue
// circular FIFO of core requests, one credit back per pop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "dcache_defs.svh"

module req_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid_i,
    input  cache_bus_pkg::dc_req_t req_i,
    output logic                   head_valid_o,
    output cache_bus_pkg::dc_req_t head_o,
    input  logic                   pop_i,
    output logic                   credit_o
);

    localparam int PTR_W = $clog2(`DC_CREDITS);
    localparam int CNT_W = $clog2(`DC_CREDITS + 1);

    cache_bus_pkg::dc_req_t fifo_mem [`DC_CREDITS];
    logic [PTR_W-1:0]       wr_ptr_q;
    logic [PTR_W-1:0]       rd_ptr_q;
    logic [CNT_W-1:0]       count_q;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`DC_CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (req_valid_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            count_q  <= count_q + CNT_W'(req_valid_i) - CNT_W'(pop_i);
            // one credit per entry that leaves
            credit_o <= pop_i;
        end
    end

    // at most one entry per credit the core holds
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            fifo_mem[wr_ptr_q] <= req_i;
        end
    end

    assign head_valid_o = (count_q != '0);
    assign head_o       = fifo_mem[rd_ptr_q];

endmodule

// File: rtl/tag_lookup.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag lookup
// tag, valid, dirty and lru arrays with a registered
// two-way compare and victim choice
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "dcache_defs.svh"

module tag_lookup (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       head_valid_i,
    input  cache_bus_pkg::dc_req_t     head_i,
    input  logic                       engine_idle_i,
    output logic                       pop_o,
    output logic                       res_valid_o,
    output cache_geom_pkg::dc_lookup_t res_o,
    input  cache_bus_pkg::dc_tag_upd_t upd_i
);

    cache_geom_pkg::dc_tag_t            tag_mem [`DC_WAYS][`DC_SETS];
    logic [`DC_WAYS-1:0][`DC_SETS-1:0]  valid_q;
    logic [`DC_WAYS-1:0][`DC_SETS-1:0]  dirty_q;
    logic [`DC_SETS-1:0]                lru_q;

    cache_geom_pkg::dc_addr_u   head_addr;
    cache_geom_pkg::dc_index_t  idx;
    logic [`DC_WAYS-1:0]        match;
    logic                       victim;
    logic                       upd_same_line;
    cache_geom_pkg::dc_lookup_t res_d;

    // only one request in flight, so a lookup always sees finished updates
    assign pop_o = head_valid_i && engine_idle_i && !res_valid_o;

    always_comb begin
        head_addr.raw = head_i.addr;
        idx           = head_addr.f.index;
        for (int w = 0; w < `DC_WAYS; w++) begin
            match[w] = valid_q[w][idx] && (tag_mem[w][idx] == head_addr.f.tag);
        end
        // free way first, else the one not used last
        if (!valid_q[0][idx]) begin
            victim = 1'b0;
        end else if (!valid_q[1][idx]) begin
            victim = 1'b1;
        end else begin
            victim = !lru_q[idx];
        end
        res_d.req          = head_i;
        res_d.hit          = |match;
        res_d.hit_way      = match[1];
        res_d.victim_way   = victim;
        res_d.victim_valid = valid_q[victim][idx];
        res_d.victim_dirty = dirty_q[victim][idx];
        res_d.victim_tag   = tag_mem[victim][idx];
    end

    // a hit rewrites its own line, dirty stays set
    assign upd_same_line = valid_q[upd_i.way][upd_i.index]
                           && (tag_mem[upd_i.way][upd_i.index] == upd_i.tag);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            res_valid_o <= 1'b0;
            valid_q     <= '0;
            dirty_q     <= '0;
            lru_q       <= '0;
        end else begin
            res_valid_o <= pop_o;
            if (upd_i.en) begin
                valid_q[upd_i.way][upd_i.index] <= upd_i.valid;
                dirty_q[upd_i.way][upd_i.index] <= upd_i.dirty
                    || (upd_same_line && dirty_q[upd_i.way][upd_i.index]);
                lru_q[upd_i.index]              <= upd_i.lru_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            res_o <= res_d;
        end
        if (upd_i.en) begin
            tag_mem[upd_i.way][upd_i.index] <= upd_i.tag;
        end
    end

endmodule

// File: rtl/way_data_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// way data array
// one word per line, both ways read each cycle,
// byte-masked write into one way
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "dcache_defs.svh"

module way_data_ram (
    input  logic                                clk,
    input  cache_geom_pkg::dc_index_t           rd_index_i,
    output logic [`DC_WAYS-1:0][`DC_DATA_W-1:0] rd_data_o,
    input  logic                                wr_en_i,
    input  logic                                wr_way_i,
    input  cache_geom_pkg::dc_index_t           wr_index_i,
    input  logic [`DC_DATA_W-1:0]               wr_data_i,
    input  logic [`DC_MASK_W-1:0]               wr_mask_i
);

    logic [`DC_DATA_W-1:0] mem [`DC_WAYS][`DC_SETS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (wr_en_i && (int'(wr_way_i) == w)) begin
                for (int b = 0; b < `DC_MASK_W; b++) begin
                    if (wr_mask_i[b]) begin
                        mem[w][wr_index_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                    end
                end
            end
            rd_data_o[w] <= mem[w][rd_index_i];
        end
    end

endmodule

// File: testbench/mem_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// backing memory model
// word store behind the cache, acknowledge after a
// pseudo-random delay, read and write counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "dcache_defs.svh"

module mem_model #(
    parameter logic [`DC_DATA_W-1:0] FILL_PATTERN = '0,
    parameter logic [15:0]           LFSR_SEED    = 16'd34
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid_i,
    input  cache_bus_pkg::dc_mem_req_t req_i,
    output logic                       ack_o,
    output logic [`DC_DATA_W-1:0]      rdata_o,
    output int                         read_count_o,
    output int                         write_count_o,
    output logic [`DC_ADDR_W-1:0]      last_wr_addr_o,
    output logic [`DC_DATA_W-1:0]      last_wr_data_o
);

    logic [`DC_DATA_W-1:0] words [logic [`DC_ADDR_W-1:0]];
    logic [15:0]           lfsr_q;
    logic                  busy_q;
    int                    wait_q;
    int                    delay_d;
    logic [`DC_ADDR_W-1:0] key;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // untouched words hold their address xor the fill pattern
    function automatic logic [`DC_DATA_W-1:0] word_at(input logic [`DC_ADDR_W-1:0] a);
        if (words.exists(a)) begin
            return words[a];
        end
        return a ^ FILL_PATTERN;
    endfunction

    // three bits, one lfsr step each, give 1 to 8 cycles
    task automatic draw_delay(output int delay);
        logic [2:0] bits;
        for (int i = 0; i < 3; i++) begin
            bits[i] = lfsr_q[0];
            lfsr_q  = lfsr_step(lfsr_q);
        end
        delay = int'(bits) + 1;
    endtask

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            ack_o          <= 1'b0;
            rdata_o        <= '0;
            busy_q         <= 1'b0;
            wait_q         <= 0;
            read_count_o   <= 0;
            write_count_o  <= 0;
            last_wr_addr_o <= '0;
            last_wr_data_o <= '0;
            lfsr_q          = LFSR_SEED;
        end else begin
            ack_o <= 1'b0;
            // the request changes on the edge after an ack
            if (!ack_o) begin
                if (busy_q) begin
                    if (wait_q <= 1) begin
                        key = {req_i.addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
                        ack_o  <= 1'b1;
                        busy_q <= 1'b0;
                        if (req_i.write) begin
                            words[key]      = req_i.wdata;
                            write_count_o  <= write_count_o + 1;
                            last_wr_addr_o <= req_i.addr;
                            last_wr_data_o <= req_i.wdata;
                        end else begin
                            rdata_o      <= word_at(key);
                            read_count_o <= read_count_o + 1;
                        end
                    end else begin
                        wait_q <= wait_q - 1;
                    end
                end else if (req_valid_i) begin
                    draw_delay(delay_d);
                    busy_q <= 1'b1;
                    wait_q <= delay_d;
                end
            end
        end
    end

endmodule

// File: testbench/tb_dcache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dcache testbench
// table of loads and stores against a golden memory
// and a tag model, credit flow on the core side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "dcache_defs.svh"

module tb_dcache;

    localparam logic [`DC_DATA_W-1:0] FILL = 64'h5A3C_96E1_0FF0_C3A5;
    localparam int MAX_ROWS   = 32;
    localparam int RESET_CYC  = 16;
    // lookup, write-back and refill at 8-cycle acks, then the response
    localparam int WORST_MISS = 32;

    typedef struct packed {
        logic                  write;
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_DATA_W-1:0] data;
        logic [`DC_MASK_W-1:0] mask;
        logic [`DC_DATA_W-1:0] exp_rdata;
        int                    exp_reads;
        int                    exp_writes;
        logic                  has_wb;
        logic [`DC_ADDR_W-1:0] wb_addr;
        logic [`DC_DATA_W-1:0] wb_data;
    } table_row_t;

    logic                       clk;
    logic                       rst;
    logic                       req_valid;
    cache_bus_pkg::dc_req_t     req;
    logic                       credit;
    logic                       resp_valid;
    cache_bus_pkg::dc_resp_t    resp;
    logic                       mem_req_valid;
    cache_bus_pkg::dc_mem_req_t mem_req;
    logic                       mem_ack;
    logic [`DC_DATA_W-1:0]      mem_rdata;
    int                         mem_reads;
    int                         mem_writes;
    logic [`DC_ADDR_W-1:0]      last_wr_addr;
    logic [`DC_DATA_W-1:0]      last_wr_data;

    table_row_t            rows [MAX_ROWS];
    int                    n_rows;
    logic [`DC_DATA_W-1:0] gold_mem [logic [`DC_ADDR_W-1:0]];
    logic [`DC_TAG_W-1:0]  ref_tag   [2][`DC_SETS];
    logic                  ref_valid [2][`DC_SETS];
    logic                  ref_dirty [2][`DC_SETS];
    logic                  ref_lru   [`DC_SETS];
    int                    pred_reads;
    int                    pred_writes;
    int                    checks;
    int                    errors;
    int                    sent;
    int                    done;
    int                    credits;
    int                    credit_pulses;
    int                    stall;
    int                    cycles;
    int                    limit;

    dcache_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid),
        .req_i           (req),
        .credit_o        (credit),
        .resp_valid_o    (resp_valid),
        .resp_o          (resp),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_o       (mem_req),
        .mem_ack_i       (mem_ack),
        .mem_rdata_i     (mem_rdata)
    );

    mem_model #(.FILL_PATTERN(FILL), .LFSR_SEED(16'd34)) mem0 (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (mem_req_valid),
        .req_i          (mem_req),
        .ack_o          (mem_ack),
        .rdata_o        (mem_rdata),
        .read_count_o   (mem_reads),
        .write_count_o  (mem_writes),
        .last_wr_addr_o (last_wr_addr),
        .last_wr_data_o (last_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [`DC_ADDR_W-1:0] make_addr(input logic [`DC_TAG_W-1:0] tag,
                                                        input logic [`DC_INDEX_W-1:0] idx);
        return {tag, idx, {`DC_OFFSET_W{1'b0}}};
    endfunction

    function automatic logic [`DC_DATA_W-1:0] gold_word(input logic [`DC_ADDR_W-1:0] a);
        if (gold_mem.exists(a)) begin
            return gold_mem[a];
        end
        return a ^ FILL;
    endfunction

    function automatic logic [`DC_DATA_W-1:0] merge_bytes(input logic [`DC_DATA_W-1:0] old,
                                                          input logic [`DC_DATA_W-1:0] data,
                                                          input logic [`DC_MASK_W-1:0] mask);
        logic [`DC_DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < `DC_MASK_W; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // predicts data and memory traffic with its own two-way lru tags
    task automatic add_row(input logic write, input logic [`DC_ADDR_W-1:0] addr,
                           input logic [`DC_DATA_W-1:0] data,
                           input logic [`DC_MASK_W-1:0] mask);
        table_row_t             row;
        logic [`DC_INDEX_W-1:0] idx;
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_ADDR_W-1:0]  line;
        logic                   way;
        logic                   hit;
        idx  = addr[`DC_OFFSET_W +: `DC_INDEX_W];
        tag  = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
        line = {addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
        row       = '0;
        row.write = write;
        row.addr  = addr;
        row.data  = data;
        row.mask  = mask;
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][idx] && (ref_tag[w][idx] == tag)) begin
                hit = 1'b1;
                way = (w == 1);
            end
        end
        if (!hit) begin
            if (!ref_valid[0][idx]) begin
                way = 1'b0;
            end else if (!ref_valid[1][idx]) begin
                way = 1'b1;
            end else begin
                way = !ref_lru[idx];
            end
            if (ref_valid[way][idx] && ref_dirty[way][idx]) begin
                row.has_wb  = 1'b1;
                row.wb_addr = make_addr(ref_tag[way][idx], idx);
                row.wb_data = gold_word(row.wb_addr);
                pred_writes++;
            end
            pred_reads++;
            ref_tag[way][idx]   = tag;
            ref_valid[way][idx] = 1'b1;
            ref_dirty[way][idx] = 1'b0;
        end
        if (write) begin
            gold_mem[line]      = merge_bytes(gold_word(line), data, mask);
            ref_dirty[way][idx] = 1'b1;
        end
        ref_lru[idx]   = way;
        row.exp_rdata  = gold_word(line);
        row.exp_reads  = pred_reads;
        row.exp_writes = pred_writes;
        rows[n_rows]   = row;
        n_rows++;
    endtask

    task automatic build_table();
        for (int s = 0; s < `DC_SETS; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_dirty[0][s] = 1'b0;
            ref_dirty[1][s] = 1'b0;
            ref_lru[s]      = 1'b0;
        end
        // load miss, hit, store hit, merged reload
        add_row(1'b0, make_addr(55'd1, 6'd5), '0, '0);
        add_row(1'b0, make_addr(55'd1, 6'd5), '0, '0);
        add_row(1'b1, make_addr(55'd1, 6'd5), 64'h1122_3344_5566_7788, 8'h0F);
        add_row(1'b0, make_addr(55'd1, 6'd5), '0, '0);
        // third tag in set 5 pushes out the dirty line
        add_row(1'b0, make_addr(55'd2, 6'd5), '0, '0);
        add_row(1'b0, make_addr(55'd3, 6'd5), '0, '0);
        add_row(1'b0, make_addr(55'd1, 6'd5), '0, '0);
        // A, B, A, C in set 9, then A and B again
        add_row(1'b0, make_addr(55'd4, 6'd9), '0, '0);
        add_row(1'b0, make_addr(55'd5, 6'd9), '0, '0);
        add_row(1'b0, make_addr(55'd4, 6'd9), '0, '0);
        add_row(1'b0, make_addr(55'd6, 6'd9), '0, '0);
        add_row(1'b0, make_addr(55'd4, 6'd9), '0, '0);
        add_row(1'b0, make_addr(55'd5, 6'd9), '0, '0);
        // store miss allocates, then reads back
        add_row(1'b1, make_addr(55'd7, 6'd20), 64'hDEAD_BEEF_CAFE_F00D, 8'hF0);
        add_row(1'b0, make_addr(55'd7, 6'd20), '0, '0);
    endtask

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("ERR time %0t %s actual %h expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_response(input int idx);
        int errs_before;
        errs_before = errors;
        compare_value("resp_o.write", 64'(resp.write), 64'(rows[idx].write));
        if (!rows[idx].write) begin
            compare_value("resp_o.rdata", resp.rdata, rows[idx].exp_rdata);
        end
        compare_value("mem read count", 64'(mem_reads), 64'(rows[idx].exp_reads));
        compare_value("mem write count", 64'(mem_writes), 64'(rows[idx].exp_writes));
        if (rows[idx].has_wb) begin
            compare_value("mem write addr", last_wr_addr, rows[idx].wb_addr);
            compare_value("mem write data", last_wr_data, rows[idx].wb_data);
        end
        $display("test %0d %s addr %h %s", idx, rows[idx].write ? "store" : "load",
                 rows[idx].addr, (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        rst           = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        n_rows        = 0;
        pred_reads    = 0;
        pred_writes   = 0;
        checks        = 0;
        errors        = 0;
        sent          = 0;
        done          = 0;
        credits       = `DC_CREDITS;
        credit_pulses = 0;
        stall         = 0;
        cycles        = 0;
        build_table();
        limit = RESET_CYC + n_rows * WORST_MISS + 100;
        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        while ((done < n_rows) && (cycles < limit)) begin
            @(negedge clk);
            cycles++;
            req_valid = 1'b0;
            if (credit) begin
                credits++;
                credit_pulses++;
            end
            if (resp_valid) begin
                check_response(done);
                done++;
            end
            if (credits == 0) begin
                stall++;
                if (stall == WORST_MISS + 1) begin
                    $display("core held no credit for more than %0d cycles", WORST_MISS);
                    errors++;
                end
            end else begin
                stall = 0;
            end
            if ((sent < n_rows) && (credits > 0)) begin
                req.write = rows[sent].write;
                req.addr  = rows[sent].addr;
                req.wdata = rows[sent].data;
                req.mask  = rows[sent].mask;
                req_valid = 1'b1;
                credits--;
                sent++;
            end
        end
        req_valid = 1'b0;

        if (done < n_rows) begin
            $display("timeout after %0d cycles with %0d of %0d responses",
                     cycles, done, n_rows);
            errors++;
        end else begin
            compare_value("credit_o pulses", 64'(credit_pulses), 64'(n_rows));
            compare_value("credits held", 64'(credits), 64'(`DC_CREDITS));
        end
        $display("tests %0d of %0d, checks %0d, errors %0d", done, n_rows, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
